// ==== Bender.yml ====
package:
  name: pellet

sources:
  - logic/pacPkg.sv
  - logic/videoTiming.sv
  - logic/eatIntake.sv
  - logic/eatQueue.sv
  - logic/pelletBoard.sv
  - logic/pelletTop.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/pelletTb.sv

// ==== build.f ====
+incdir+tests
logic/pacPkg.sv
logic/videoTiming.sv
logic/eatIntake.sv
logic/eatQueue.sv
logic/pelletBoard.sv
logic/pelletTop.sv
tests/pelletTb.sv

// ==== logic/eatIntake.sv ====
module eatIntake import pacPkg::*; #(
  parameter int queueDepth = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       eatValid,
  input  cellCoord_t eatCol,
  input  cellCoord_t eatRow,
  output logic       eatReady,
  output logic       pushValid,
  output cellCoord_t pushCol,
  output cellCoord_t pushRow,
  input  logic       creditReturn
);

  localparam int credW = $clog2(queueDepth + 1);

  logic [credW-1:0] credits;
  logic             accept;

  assign eatReady = (credits != '0);
  assign accept   = eatValid && eatReady;

  // take and return can land on the same edge
  always_ff @(posedge clk) begin
    if (reset) begin
      credits   <= credW'(queueDepth);
      pushValid <= 1'b0;
    end else begin
      credits   <= credits - credW'(accept) + credW'(creditReturn);
      pushValid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pushCol <= eatCol;
      pushRow <= eatRow;
    end
  end

  // a credit comes back only for an entry that was pushed before
  creditBound: assert property (@(posedge clk) disable iff (reset)
    credits <= credW'(queueDepth));

endmodule

// ==== logic/eatQueue.sv ====
module eatQueue import pacPkg::*; #(
  parameter int queueDepth = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       pushValid,
  input  cellCoord_t pushCol,
  input  cellCoord_t pushRow,
  output logic       popValid,
  output cellCoord_t popCol,
  output cellCoord_t popRow,
  input  logic       popTaken,
  output logic       creditReturn
);

  localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
  localparam int cntW = $clog2(queueDepth + 1);

  cellCoord_t colMem [queueDepth];
  cellCoord_t rowMem [queueDepth];

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;

  always_ff @(posedge clk) begin
    if (pushValid) begin
      colMem[wrPtr] <= pushCol;
      rowMem[wrPtr] <= pushRow;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (pushValid)
        wrPtr <= (wrPtr == ptrW'(queueDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (popTaken)
        rdPtr <= (rdPtr == ptrW'(queueDepth - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + cntW'(pushValid) - cntW'(popTaken);
    end
  end

  assign popValid     = (count != '0);
  assign popCol       = colMem[rdPtr];  // head of queue
  assign popRow       = rowMem[rdPtr];
  assign creditReturn = popTaken;       // one credit per removed entry

  // intake credits must keep pushes away from a full queue
  noOverflow: assert property (@(posedge clk) disable iff (reset)
    !(pushValid && count == cntW'(queueDepth)));

  noUnderflow: assert property (@(posedge clk) disable iff (reset)
    !(popTaken && count == '0));

endmodule

// ==== logic/pacPkg.sv ====
package pacPkg;

  typedef logic [9:0]  hPos_t;
  typedef logic [9:0]  vPos_t;
  typedef logic [4:0]  cellCoord_t;  // 16x16 pixel cells
  typedef logic [3:0]  pixelOfs_t;
  typedef logic [15:0] score_t;
  typedef logic [3:0]  color_t;

  localparam color_t colBlack = 4'd0;
  localparam color_t colWhite = 4'd15;

  // 800x525 frame, syncs active low
  localparam hPos_t hVisible   = 10'd640;
  localparam hPos_t hTotal     = 10'd800;
  localparam hPos_t hSyncStart = 10'd656;
  localparam hPos_t hSyncEnd   = 10'd752;

  localparam vPos_t vVisible   = 10'd480;
  localparam vPos_t vTotal     = 10'd525;
  localparam vPos_t vSyncStart = 10'd490;
  localparam vPos_t vSyncEnd   = 10'd492;

  localparam int boardCols = 28;
  localparam int boardRows = 30;

  localparam score_t pelletPoints = 16'd1;
  localparam score_t powerPoints  = 16'd5;

  // energizers sit in the four corners of the maze
  function automatic logic isPowerCell(cellCoord_t col, cellCoord_t row);
    return (col == 5'd2 || col == 5'd27) && (row == 5'd4 || row == 5'd24);
  endfunction

endpackage

// ==== logic/pelletBoard.sv ====
module pelletBoard import pacPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  hPos_t      hPos,
  input  vPos_t      vPos,
  input  logic       displayOn,
  input  logic       popValid,
  input  cellCoord_t popCol,
  input  cellCoord_t popRow,
  output logic       popTaken,
  output score_t     score,
  output color_t     rgb
);

  localparam hPos_t fieldW = hPos_t'(boardCols * 16);
  localparam vPos_t fieldH = vPos_t'(boardRows * 16);

  // one bit per cell, set while the pellet is still there
  logic [boardCols-1:0] pelletBits [boardRows];

  cellCoord_t beamCol;
  cellCoord_t beamRow;
  pixelOfs_t  ofsX;
  pixelOfs_t  ofsY;
  logic       beamInField;
  logic       beamPellet;
  logic       dotShape;
  logic       popHit;

  assign beamCol     = hPos[8:4];
  assign beamRow     = vPos[8:4];
  assign ofsX        = hPos[3:0];
  assign ofsY        = vPos[3:0];
  assign beamInField = displayOn && (hPos < fieldW) && (vPos < fieldH);

  always_comb begin
    beamPellet = 1'b0;
    if (beamInField)
      beamPellet = pelletBits[beamRow][beamCol];
  end

  // energizers draw a bigger dot
  always_comb begin
    if (isPowerCell(beamCol, beamRow))
      dotShape = (ofsX >= 4'd4) && (ofsX <= 4'd11) && (ofsY >= 4'd4) && (ofsY <= 4'd11);
    else
      dotShape = (ofsX >= 4'd6) && (ofsX <= 4'd9) && (ofsY >= 4'd6) && (ofsY <= 4'd9);
  end

  // queue is only worked off below the visible lines
  assign popTaken = popValid && (vPos >= vVisible);

  always_comb begin
    popHit = 1'b0;
    if (popCol < boardCols && popRow < boardRows)
      popHit = pelletBits[popRow][popCol];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < boardRows; r++)
        pelletBits[r] <= '1;
      score <= '0;
    end else if (popTaken && popHit) begin
      pelletBits[popRow][popCol] <= 1'b0;
      score <= score + (isPowerCell(popCol, popRow) ? powerPoints : pelletPoints);
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      rgb <= colBlack;
    else
      rgb <= (beamPellet && dotShape) ? colWhite : colBlack;  // belongs to last beam pos
  end

endmodule

// ==== logic/pelletTop.sv ====
module pelletTop import pacPkg::*; #(
  parameter int queueDepth = 4
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       eatValid,
  input  cellCoord_t eatCol,
  input  cellCoord_t eatRow,
  output logic       eatReady,
  output logic       hsync,
  output logic       vsync,
  output score_t     score,
  output color_t     rgb
);

  hPos_t      hPos;
  vPos_t      vPos;
  logic       displayOn;

  logic       pushValid;
  cellCoord_t pushCol;
  cellCoord_t pushRow;
  logic       creditReturn;

  logic       popValid;
  cellCoord_t popCol;
  cellCoord_t popRow;
  logic       popTaken;

  videoTiming video_i (
    .clk       (clk),
    .reset     (reset),
    .hsync     (hsync),
    .vsync     (vsync),
    .displayOn (displayOn),
    .hPos      (hPos),
    .vPos      (vPos)
  );

  eatIntake #(.queueDepth(queueDepth)) intake_i (
    .clk          (clk),
    .reset        (reset),
    .eatValid     (eatValid),
    .eatCol       (eatCol),
    .eatRow       (eatRow),
    .eatReady     (eatReady),
    .pushValid    (pushValid),
    .pushCol      (pushCol),
    .pushRow      (pushRow),
    .creditReturn (creditReturn)
  );

  eatQueue #(.queueDepth(queueDepth)) queue_i (
    .clk          (clk),
    .reset        (reset),
    .pushValid    (pushValid),
    .pushCol      (pushCol),
    .pushRow      (pushRow),
    .popValid     (popValid),
    .popCol       (popCol),
    .popRow       (popRow),
    .popTaken     (popTaken),
    .creditReturn (creditReturn)
  );

  pelletBoard board_i (
    .clk       (clk),
    .reset     (reset),
    .hPos      (hPos),
    .vPos      (vPos),
    .displayOn (displayOn),
    .popValid  (popValid),
    .popCol    (popCol),
    .popRow    (popRow),
    .popTaken  (popTaken),
    .score     (score),
    .rgb       (rgb)
  );

endmodule

// ==== logic/videoTiming.sv ====
module videoTiming import pacPkg::*; (
  input  logic  clk,
  input  logic  reset,
  output logic  hsync,
  output logic  vsync,
  output logic  displayOn,
  output hPos_t hPos,
  output vPos_t vPos
);

  logic lineEnd;
  logic frameEnd;

  assign lineEnd  = (hPos == hTotal - 1);
  assign frameEnd = (vPos == vTotal - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      hPos <= '0;
      vPos <= '0;
    end else if (lineEnd) begin
      hPos <= '0;
      vPos <= frameEnd ? '0 : vPos + 1'b1;
    end else begin
      hPos <= hPos + 1'b1;
    end
  end

  // syncs come out one cycle behind the counters
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      hsync <= !(hPos >= hSyncStart && hPos < hSyncEnd);
      vsync <= !(vPos >= vSyncStart && vPos < vSyncEnd);
    end
  end

  assign displayOn = (hPos < hVisible) && (vPos < vVisible);

endmodule

// ==== tests/pelletTasks.svh ====
function automatic bit energizerAt(input int col, input int row);
  return (col == 2 || col == 27) && (row == 4 || row == 24);
endfunction

function automatic logic syncLevel(input bit vertical);
  return vertical ? vsync : hsync;
endfunction

task automatic reportMismatch(input string name, input int expected, input int actual);
  mismatchCount++;
  $display("CHECK FAILED at time %0t: %s expected %0d, got %0d", $time, name, expected, actual);
endtask

// score model updated once per accepted request
task automatic predictEat(input int col, input int row);
  if (col < boardCols && row < boardRows && !eatenModel[col][row]) begin
    eatenModel[col][row] = 1'b1;
    expectedScore += energizerAt(col, row) ? 5 : 1;
  end
endtask

task automatic pickCell(output int col, output int row);
  col = {$random(seed)} % boardCols;
  row = {$random(seed)} % boardRows;
  while (energizerAt(col, row) || eatenModel[col][row]) begin
    col = {$random(seed)} % boardCols;
    row = {$random(seed)} % boardRows;
  end
endtask

task automatic sendEat(input int col, input int row);
  eatValid = 1'b1;
  eatCol   = cellCoord_t'(col);
  eatRow   = cellCoord_t'(row);
  while (!eatReady)
    @(negedge clk);
  @(negedge clk);  // accepted on the edge in between
  eatValid = 1'b0;
  predictEat(col, row);
endtask

task automatic waitScore(input int limit);
  int cycles;
  cycles = 0;
  while (score < expectedScore && cycles < limit) begin
    @(negedge clk);
    cycles++;
  end
  if (score < expectedScore) begin
    otherCount++;
    $display("score stuck at %0d for %0d cycles, waiting for %0d", score, limit, expectedScore);
  end else if (score != expectedScore) begin
    reportMismatch("score", expectedScore, score);
  end
endtask

task automatic expectPixel(input int x, input int y, input color_t expected);
  while (!(prevH == x && prevV == y))
    @(negedge clk);
  if (rgb !== expected)
    reportMismatch($sformatf("rgb at (%0d,%0d)", x, y), expected, rgb);
endtask

// distance between two falling edges and the low phase after the first one
task automatic measureSync(input bit vertical, input string name, input int period,
                           input int lowLen);
  logic prevLevel;
  logic level;
  int   lowCycles;
  int   cycles;
  bit   seenHigh;
  level     = syncLevel(vertical);
  prevLevel = level;
  while (!(prevLevel && !level)) begin
    prevLevel = level;
    @(negedge clk);
    level = syncLevel(vertical);
  end
  lowCycles = 1;
  cycles    = 0;
  seenHigh  = 1'b0;
  while (!(seenHigh && !level)) begin
    @(negedge clk);
    cycles++;
    level = syncLevel(vertical);
    if (level)
      seenHigh = 1'b1;
    else if (!seenHigh)
      lowCycles++;
  end
  if (lowCycles != lowLen)
    reportMismatch({name, " low cycles"}, lowLen, lowCycles);
  if (cycles != period)
    reportMismatch({name, " period"}, period, cycles);
endtask

task automatic resetValues();
  if (eatReady !== 1'b1)
    reportMismatch("eatReady", 1, eatReady);
  if (score !== 16'd0)
    reportMismatch("score", 0, score);
  if (hsync !== 1'b1)
    reportMismatch("hsync", 1, hsync);
  if (vsync !== 1'b1)
    reportMismatch("vsync", 1, vsync);
  if (rgb !== colBlack)
    reportMismatch("rgb", colBlack, rgb);
endtask

task automatic frameTiming();
  measureSync(1'b0, "hsync", lineCycles, 96);
  measureSync(1'b1, "vsync", frameCycles, 2 * lineCycles);
endtask

// all four pixels come in raster order within one frame
task automatic pixelRendering();
  expectPixel(2 * 16 + 4, 4 * 16 + 4, colWhite);  // energizer at offset 4
  expectPixel(5 * 16, 5 * 16, colBlack);
  expectPixel(5 * 16 + 7, 5 * 16 + 7, colWhite);
  expectPixel(32 * 16 + 5 * 16 + 7, 6 * 16 + 7, colBlack);  // right of the field at a dot centre
endtask

task automatic pelletEating();
  int col;
  int row;
  int keys [3];
  int tmp;
  for (int i = 0; i < 3; i++) begin
    pickCell(col, row);
    sendEat(col, row);
    keys[i] = (row * 16 + 7) * lineCycles + col * 16 + 7;
  end
  waitScore(frameCycles);
  for (int i = 0; i < 2; i++) begin
    for (int j = 0; j < 2 - i; j++) begin
      if (keys[j] > keys[j + 1]) begin
        tmp         = keys[j];
        keys[j]     = keys[j + 1];
        keys[j + 1] = tmp;
      end
    end
  end
  for (int i = 0; i < 3; i++)
    expectPixel(keys[i] % lineCycles, keys[i] / lineCycles, colBlack);
endtask

task automatic specialCells();
  int col;
  int row;
  sendEat(2, 4);
  waitScore(frameCycles);
  pickCell(col, row);
  sendEat(2, 4);
  sendEat(30, 5);
  sendEat(col, row);  // the ordinary cell goes last so its point marks the end
  waitScore(frameCycles);
endtask

task automatic backPressure();
  int col;
  int row;
  int accepted;
  bit ready;
  bit stalled;
  bit resumed;
  accepted = 0;
  stalled  = 1'b0;
  resumed  = 1'b0;
  while (!(tbH == 0 && tbV == 0))
    @(negedge clk);
  pickCell(col, row);
  while (accepted < 6) begin
    eatValid = 1'b1;
    eatCol   = cellCoord_t'(col);
    eatRow   = cellCoord_t'(row);
    ready    = eatReady;
    if (!ready && !stalled) begin
      stalled = 1'b1;
      if (accepted != depth)
        reportMismatch("requests accepted before stall", depth, accepted);
    end
    if (ready && stalled && !resumed) begin
      resumed = 1'b1;
      if (tbV != visibleLines)
        reportMismatch("vPos when eatReady rose", visibleLines, tbV);
    end
    @(negedge clk);
    if (ready) begin
      predictEat(col, row);
      accepted++;
      pickCell(col, row);
    end
  end
  eatValid = 1'b0;
  if (!stalled) begin
    otherCount++;
    $display("eatReady never fell while six requests were offered");
  end
  waitScore(frameCycles);
endtask

// ==== tests/pelletTb.sv ====
module pelletTb import pacPkg::*; ();

  localparam int depth        = 4;
  localparam int clkPeriod    = 20;
  localparam int lineCycles   = 800;
  localparam int frameLines   = 525;
  localparam int visibleLines = 480;
  localparam int frameCycles  = lineCycles * frameLines;

  logic       clk;
  logic       reset;
  logic       eatValid;
  cellCoord_t eatCol;
  cellCoord_t eatRow;
  logic       eatReady;
  logic       hsync;
  logic       vsync;
  score_t     score;
  color_t     rgb;

  int     tbH;
  int     tbV;
  int     prevH;  // beam position that the current rgb belongs to
  int     prevV;
  int     mismatchCount;
  int     otherCount;
  int     expectedScore;
  integer seed;
  bit     eatenModel [32][32];

  pelletTop #(.queueDepth(depth)) dut_i (
    .clk      (clk),
    .reset    (reset),
    .eatValid (eatValid),
    .eatCol   (eatCol),
    .eatRow   (eatRow),
    .eatReady (eatReady),
    .hsync    (hsync),
    .vsync    (vsync),
    .score    (score),
    .rgb      (rgb)
  );

  initial clk = 1'b0;
  always #(clkPeriod / 2) clk = ~clk;

  // reference beam, in step with the DUT counters
  always @(posedge clk) begin
    if (reset) begin
      tbH   <= 0;
      tbV   <= 0;
      prevH <= 0;
      prevV <= 0;
    end else begin
      prevH <= tbH;
      prevV <= tbV;
      if (tbH == lineCycles - 1) begin
        tbH <= 0;
        tbV <= (tbV == frameLines - 1) ? 0 : tbV + 1;
      end else begin
        tbH <= tbH + 1;
      end
    end
  end

  `include "pelletTasks.svh"

  initial begin
    repeat (6 * frameCycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, tests did not finish", 6 * frameCycles);
    $display("Test failures found");
    $finish;
  end

  initial begin
    seed          = 32'h3ef8;
    mismatchCount = 0;
    otherCount    = 0;
    expectedScore = 0;
    reset         = 1'b1;
    eatValid      = 1'b0;
    eatCol        = '0;
    eatRow        = '0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    resetValues();
    frameTiming();
    pixelRendering();
    pelletEating();
    specialCells();
    backPressure();
    $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
    if (mismatchCount + otherCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
